//--- all.f
+incdir+hdl
hdl/ex_arith_pkg.sv
hdl/ex_pipe_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult_ctrl.sv
hdl/ex_mult_step_counter.sv
hdl/ex_mult.sv
hdl/ex_commit.sv
hdl/ex_stage.sv
test/tb_clock_gen.sv
test/ex_stage_tb.sv

//--- hdl/ex_alu.sv
`timescale 1ns/10ps
`default_nettype none
`include "ex_consts.svh"

module ex_alu
  import ex_arith_pkg::*;
(
  input  alu_req_t alu_req_i,
  output data_t    result_o,
  output logic     cmp_result_o
);

  // Shift amount from low bits of b
  logic [$clog2(`EX_XLEN)-1:0] shamt;
  logic                        is_cmp;
  logic                        cmp;
  logic                        equal;
  logic                        lt_signed;
  logic                        lt_unsigned;
  data_t                       arith;

  assign shamt = alu_req_i.b[$clog2(`EX_XLEN)-1:0];

  // Shared comparators
  assign equal       = (alu_req_i.a == alu_req_i.b);
  assign lt_signed   = ($signed(alu_req_i.a) < $signed(alu_req_i.b));
  assign lt_unsigned = (alu_req_i.a < alu_req_i.b);

  // Arithmetic, logic and shifts
  always_comb begin
    case (alu_req_i.op)
      ADD:     arith = alu_req_i.a + alu_req_i.b;
      SUB:     arith = alu_req_i.a - alu_req_i.b;
      AND:     arith = alu_req_i.a & alu_req_i.b;
      OR:      arith = alu_req_i.a | alu_req_i.b;
      XOR:     arith = alu_req_i.a ^ alu_req_i.b;
      SLL:     arith = alu_req_i.a << shamt;
      SRL:     arith = alu_req_i.a >> shamt;
      // Arithmetic shift keeps the sign
      SRA:     arith = $signed(alu_req_i.a) >>> shamt;
      default: arith = '0;
    endcase
  end

  // Comparison select
  always_comb begin
    is_cmp = 1'b1;
    case (alu_req_i.op)
      EQ:        cmp = equal;
      NE:        cmp = ~equal;
      SLT, LT:   cmp = lt_signed;
      GE:        cmp = ~lt_signed;
      SLTU, LTU: cmp = lt_unsigned;
      GEU:       cmp = ~lt_unsigned;
      default: begin
        // Not a comparison
        cmp    = 1'b0;
        is_cmp = 1'b0;
      end
    endcase
  end

  // Comparisons return a single flag in bit 0
  assign result_o     = is_cmp ? {{(`EX_XLEN-1){1'b0}}, cmp} : arith;
  assign cmp_result_o = cmp;

endmodule

`default_nettype wire

//--- hdl/ex_arith_pkg.sv
`default_nettype none
`include "ex_consts.svh"

package ex_arith_pkg;

  // One machine word
  typedef logic [`EX_XLEN-1:0] data_t;

  // ALU operators
  // Last eight are comparisons
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ADD, SUB, AND, OR,
    XOR, SLL, SRL, SRA,
    SLT, SLTU, EQ, NE,
    LT, GE, LTU, GEU
  } alu_op_e;

  // Multiplier operators
  // MUL is the only single-cycle one
  typedef enum logic [`EX_MULT_OP_W-1:0] {
    MUL, MULH, MULHU, MULHSU
  } mult_op_e;

  // ALU request from decode
  typedef struct packed {
    alu_op_e op;
    data_t   a;
    data_t   b;
    // Jump target, passed straight out
    data_t   c;
  } alu_req_t;

  // Multiplier request from decode
  typedef struct packed {
    mult_op_e op;
    data_t    a;
    data_t    b;
  } mult_req_t;

endpackage

`default_nettype wire

//--- hdl/ex_commit.sv
`timescale 1ns/10ps
`default_nettype none

module ex_commit
  import ex_arith_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      alu_en_i,
  input  logic      mult_en_i,
  input  logic      csr_access_i,
  input  logic      lsu_en_i,
  input  data_t     alu_result_i,
  input  data_t     mult_result_i,
  input  data_t     csr_rdata_i,
  input  data_t     lsu_rdata_i,
  input  rf_dest_t  alu_dest_i,
  input  rf_dest_t  wb_dest_i,
  input  logic      mult_ready_i,
  input  logic      lsu_ready_ex_i,
  input  logic      wb_ready_i,
  input  logic      branch_in_ex_i,
  output rf_write_t fw_port_o,
  output rf_write_t wb_port_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  logic     wb_we_q;
  rf_addr_t wb_addr_q;
  // All downstream and multiplier ready
  logic     units_ready;

  //////////////////////////////
  // Forwarding port
  //////////////////////////////

  // CSR over multiplier over ALU
  always_comb begin
    fw_port_o.we   = alu_dest_i.we;
    fw_port_o.addr = alu_dest_i.addr;
    if (csr_access_i)   fw_port_o.data = csr_rdata_i;
    else if (mult_en_i) fw_port_o.data = mult_result_i;
    else if (alu_en_i)  fw_port_o.data = alu_result_i;
    else                fw_port_o.data = '0;
  end

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  // Valid implies WB ready, else flush when WB drains
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)          wb_we_q <= 1'b0;
    else if (ex_valid_o) wb_we_q <= wb_dest_i.we;
    else if (wb_ready_i) wb_we_q <= 1'b0;
  end

  // Address only loads with a live write
  always_ff @(posedge clk) begin
    if (ex_valid_o && wb_dest_i.we) wb_addr_q <= wb_dest_i.addr;
  end

  assign wb_port_o = '{we: wb_we_q, addr: wb_addr_q, data: lsu_rdata_i};

  // Stall logic
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  // Branches resolve here without WB
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign ex_valid_o  = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

`default_nettype wire

//--- hdl/ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Data word width
`define EX_XLEN 32

// Register file address width
`define EX_RF_ADDR_W 6

// Partial-product steps per high-half multiply
`define EX_MULH_STEPS 4

// Operator field widths
`define EX_ALU_OP_W 4
`define EX_MULT_OP_W 2

`endif

//--- hdl/ex_mult.sv
`timescale 1ns/10ps
`default_nettype none
`include "ex_consts.svh"

module ex_mult
  import ex_arith_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  mult_req_t mult_req_i,
  input  logic      clear_i,
  input  logic      accumulate_i,
  input  step_t     step_i,
  output data_t     result_o
);

  localparam int HALF_W = `EX_XLEN / 2;

  logic                         sign_a;
  logic                         sign_b;
  logic                         hi_a;
  logic                         hi_b;
  logic [HALF_W:0]              half_a;
  logic [HALF_W:0]              half_b;
  logic signed [2*HALF_W+1:0]   part;
  logic [2*`EX_XLEN-1:0]        part_ext;
  logic [2*`EX_XLEN-1:0]        part_shifted;
  logic [2*`EX_XLEN-1:0]        acc_q;
  data_t                        low_product;

  //////////////////////////////
  // Single-cycle low product
  //////////////////////////////

  // Lower word only, truncated
  assign low_product = mult_req_i.a * mult_req_i.b;

  //////////////////////////////
  // Partial-product datapath
  //////////////////////////////

  // MULHSU treats only a as signed
  assign sign_a = (mult_req_i.op == MULH) || (mult_req_i.op == MULHSU);
  assign sign_b = (mult_req_i.op == MULH);

  // Step bit 1 picks a's half, bit 0 picks b's half
  assign hi_a = step_i[1];
  assign hi_b = step_i[0];

  // Low halves zero-extended, high halves by signedness
  assign half_a = hi_a ? {sign_a & mult_req_i.a[`EX_XLEN-1], mult_req_i.a[`EX_XLEN-1 -: HALF_W]}
                       : {1'b0, mult_req_i.a[HALF_W-1:0]};
  assign half_b = hi_b ? {sign_b & mult_req_i.b[`EX_XLEN-1], mult_req_i.b[`EX_XLEN-1 -: HALF_W]}
                       : {1'b0, mult_req_i.b[HALF_W-1:0]};

  // 17x17 signed product
  assign part = $signed(half_a) * $signed(half_b);

  // Sign-extend to accumulator width
  assign part_ext = {{(2*`EX_XLEN-2*HALF_W-2){part[2*HALF_W+1]}}, part};

  // Weight by position of the halves
  always_comb begin
    case ({hi_a, hi_b})
      2'b00:   part_shifted = part_ext;
      2'b11:   part_shifted = part_ext << (2 * HALF_W);
      default: part_shifted = part_ext << HALF_W;
    endcase
  end

  // Full 64-bit product builds up over the steps
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)            acc_q <= '0;
    else if (clear_i)      acc_q <= '0;
    else if (accumulate_i) acc_q <= acc_q + part_shifted;
  end

  // High multiplies return the upper word
  assign result_o = (mult_req_i.op == MUL) ? low_product : acc_q[2*`EX_XLEN-1:`EX_XLEN];

endmodule

`default_nettype wire

//--- hdl/ex_mult_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ex_mult_ctrl
  import ex_arith_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     mult_en_i,
  input  mult_op_e op_i,
  input  logic     ex_ready_i,
  input  logic     last_step_i,
  output logic     clear_o,
  output logic     accumulate_o,
  output logic     ready_o,
  output logic     multicycle_o
);

  mult_state_e state_q;
  mult_state_e state_d;
  // Request needing the multicycle path
  logic        high_req;

  assign high_req = mult_en_i && (op_i != MUL);

  always_comb begin
    state_d      = state_q;
    clear_o      = 1'b0;
    accumulate_o = 1'b0;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    case (state_q)
      IDLE: begin
        // MUL passes through with ready high
        if (high_req) begin
          clear_o = 1'b1;
          ready_o = 1'b0;
          state_d = RUN;
        end
      end
      RUN: begin
        // One partial product per cycle
        accumulate_o = 1'b1;
        ready_o      = 1'b0;
        multicycle_o = 1'b1;
        if (last_step_i) state_d = DONE;
      end
      DONE: begin
        // Result held until the stage moves on
        multicycle_o = 1'b1;
        if (ex_ready_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= IDLE;
    else        state_q <= state_d;
  end

endmodule

`default_nettype wire

//--- hdl/ex_mult_step_counter.sv
`timescale 1ns/10ps
`default_nettype none
`include "ex_consts.svh"

module ex_mult_step_counter
  import ex_pipe_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  clear_i,
  input  logic  advance_i,
  output step_t step_o,
  output logic  last_o
);

  step_t step_q;

  // Clear wins over advance
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)         step_q <= '0;
    else if (clear_i)   step_q <= '0;
    else if (advance_i) step_q <= step_q + 1'b1;
  end

  assign step_o = step_q;
  // Final partial product
  assign last_o = (step_q == step_t'(`EX_MULH_STEPS - 1));

endmodule

`default_nettype wire

//--- hdl/ex_pipe_pkg.sv
`default_nettype none
`include "ex_consts.svh"

package ex_pipe_pkg;
  import ex_arith_pkg::*;

  // Register file address
  typedef logic [`EX_RF_ADDR_W-1:0] rf_addr_t;

  // Destination request
  typedef struct packed {
    logic     we;
    rf_addr_t addr;
  } rf_dest_t;

  // Full register write port
  typedef struct packed {
    logic     we;
    rf_addr_t addr;
    data_t    data;
  } rf_write_t;

  // Multicycle controller states
  typedef enum logic [1:0] {
    IDLE, RUN, DONE
  } mult_state_e;

  // Partial-product step index
  typedef logic [$clog2(`EX_MULH_STEPS)-1:0] step_t;

endpackage

`default_nettype wire

//--- hdl/ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage
  import ex_arith_pkg::*;
  import ex_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      alu_en_i,
  input  alu_req_t  alu_req_i,
  input  logic      mult_en_i,
  input  mult_req_t mult_req_i,
  input  logic      csr_access_i,
  input  data_t     csr_rdata_i,
  input  logic      lsu_en_i,
  input  data_t     lsu_rdata_i,
  input  rf_dest_t  alu_dest_i,
  input  rf_dest_t  wb_dest_i,
  input  logic      branch_in_ex_i,
  input  logic      lsu_ready_ex_i,
  input  logic      wb_ready_i,
  output rf_write_t fw_port_o,
  output rf_write_t wb_port_o,
  output logic      branch_decision_o,
  output data_t     jump_target_o,
  output logic      mult_multicycle_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  data_t alu_result;
  data_t mult_result;
  logic  mult_ready;
  logic  mult_clear;
  logic  mult_accumulate;
  step_t mult_step;
  logic  mult_last_step;

  // Jump target comes straight from decode
  assign jump_target_o = alu_req_i.c;

  ex_alu u_alu (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  // Multicycle sequencing for high-half products
  ex_mult_ctrl u_mult_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_en_i    (mult_en_i),
    .op_i         (mult_req_i.op),
    .ex_ready_i   (ex_ready_o),
    .last_step_i  (mult_last_step),
    .clear_o      (mult_clear),
    .accumulate_o (mult_accumulate),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  // Counter advances with every accumulate
  ex_mult_step_counter u_mult_step_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear_i   (mult_clear),
    .advance_i (mult_accumulate),
    .step_o    (mult_step),
    .last_o    (mult_last_step)
  );

  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_req_i   (mult_req_i),
    .clear_i      (mult_clear),
    .accumulate_i (mult_accumulate),
    .step_i       (mult_step),
    .result_o     (mult_result)
  );

  ex_commit u_commit (
    .clk            (clk),
    .rst_n          (rst_n),
    .alu_en_i       (alu_en_i),
    .mult_en_i      (mult_en_i),
    .csr_access_i   (csr_access_i),
    .lsu_en_i       (lsu_en_i),
    .alu_result_i   (alu_result),
    .mult_result_i  (mult_result),
    .csr_rdata_i    (csr_rdata_i),
    .lsu_rdata_i    (lsu_rdata_i),
    .alu_dest_i     (alu_dest_i),
    .wb_dest_i      (wb_dest_i),
    .mult_ready_i   (mult_ready),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .wb_ready_i     (wb_ready_i),
    .branch_in_ex_i (branch_in_ex_i),
    .fw_port_o      (fw_port_o),
    .wb_port_o      (wb_port_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

endmodule

`default_nettype wire

//--- test/ex_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage_tb
  import ex_arith_pkg::*;
  import ex_pipe_pkg::*;
;

  // Several times the expected run length
  localparam int TIMEOUT_CYCLES = 4000;

  logic      clk;
  logic      rst_n;
  logic      alu_en;
  alu_req_t  alu_req;
  logic      mult_en;
  mult_req_t mult_req;
  logic      csr_access;
  data_t     csr_rdata;
  logic      lsu_en;
  data_t     lsu_rdata;
  rf_dest_t  alu_dest;
  rf_dest_t  wb_dest;
  logic      branch_in_ex;
  logic      lsu_ready_ex;
  logic      wb_ready;
  rf_write_t fw_port;
  rf_write_t wb_port;
  logic      branch_decision;
  data_t     jump_target;
  logic      mult_multicycle;
  logic      ex_ready;
  logic      ex_valid;
  int        cycle_count = 0;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage u_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_en_i          (alu_en),
    .alu_req_i         (alu_req),
    .mult_en_i         (mult_en),
    .mult_req_i        (mult_req),
    .csr_access_i      (csr_access),
    .csr_rdata_i       (csr_rdata),
    .lsu_en_i          (lsu_en),
    .lsu_rdata_i       (lsu_rdata),
    .alu_dest_i        (alu_dest),
    .wb_dest_i         (wb_dest),
    .branch_in_ex_i    (branch_in_ex),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .wb_ready_i        (wb_ready),
    .fw_port_o         (fw_port),
    .wb_port_o         (wb_port),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .mult_multicycle_o (mult_multicycle),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  //////////////////////////////
  // Reference models
  //////////////////////////////

  // Branch and set-less-than comparisons
  function automatic logic cmp_model(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      EQ:        return a == b;
      NE:        return a != b;
      SLT, LT:   return $signed(a) < $signed(b);
      GE:        return $signed(a) >= $signed(b);
      SLTU, LTU: return a < b;
      GEU:       return a >= b;
      default:   return 1'b0;
    endcase
  endfunction

  function automatic data_t alu_model(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return data_t'($signed(a) >>> b[4:0]);
      // Comparison flag in bit 0
      default: return {31'b0, cmp_model(op, a, b)};
    endcase
  endfunction

  // Full 64-bit product, then the word the operator asks for
  function automatic data_t mult_model(input mult_op_e op, input data_t a, input data_t b);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] product;
    ext_a   = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
    ext_b   = (op == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
    product = ext_a * ext_b;
    return (op == MUL) ? product[31:0] : product[63:32];
  endfunction

  task automatic check_equal(input string test_name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %0h, actual %0h", test_name, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic sweep_alu_ops;
    alu_op_e  op;
    data_t    a;
    data_t    b;
    rf_dest_t dest;
    for (int i = 0; i < 16; i++) begin
      op = alu_op_e'(i);
      for (int n = 0; n < 20; n++) begin
        a    = $urandom;
        b    = $urandom;
        dest = '{we: 1'($urandom % 2), addr: rf_addr_t'($urandom)};
        @(posedge clk);
        alu_en   <= 1'b1;
        alu_req  <= '{op: op, a: a, b: b, c: $urandom};
        alu_dest <= dest;
        @(negedge clk);
        check_equal($sformatf("alu %s data", op.name()), alu_model(op, a, b), fw_port.data);
        check_equal("alu fw we", dest.we, fw_port.we);
        check_equal("alu fw addr", dest.addr, fw_port.addr);
      end
    end
    @(posedge clk);
    alu_en <= 1'b0;
  endtask

  task automatic verify_branch_outputs;
    alu_op_e op;
    data_t   a;
    data_t   b;
    data_t   c;
    // SLT through GEU are comparisons
    for (int i = 8; i < 16; i++) begin
      op = alu_op_e'(i);
      for (int n = 0; n < 12; n++) begin
        a = $urandom;
        // Every fourth pair equal
        b = (n % 4 == 0) ? a : $urandom;
        c = $urandom;
        @(posedge clk);
        alu_en  <= 1'b1;
        alu_req <= '{op: op, a: a, b: b, c: c};
        @(negedge clk);
        check_equal($sformatf("branch %s", op.name()), cmp_model(op, a, b), branch_decision);
        check_equal("jump target", c, jump_target);
      end
    end
    @(posedge clk);
    alu_en <= 1'b0;
  endtask

  // Single multiply with stall length and result checks
  task automatic run_mult(input mult_op_e op, input data_t a, input data_t b);
    string name;
    int    low_cycles;
    name       = $sformatf("mult %s", op.name());
    low_cycles = 0;
    @(posedge clk);
    mult_en  <= 1'b1;
    mult_req <= '{op: op, a: a, b: b};
    @(negedge clk);
    while (!ex_ready) begin
      // Enable cycle in IDLE, then RUN
      check_equal({name, " multicycle"}, low_cycles != 0, mult_multicycle);
      low_cycles++;
      @(negedge clk);
    end
    check_equal({name, " stall cycles"}, (op == MUL) ? 0 : 5, low_cycles);
    check_equal({name, " multicycle at result"}, op != MUL, mult_multicycle);
    check_equal({name, " data"}, mult_model(op, a, b), fw_port.data);
    @(posedge clk);
    mult_en <= 1'b0;
  endtask

  task automatic exercise_multiplier;
    data_t    corner [3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
    mult_op_e op;
    for (int i = 0; i < 4; i++) begin
      op = mult_op_e'(i);
      foreach (corner[x]) begin
        foreach (corner[y]) run_mult(op, corner[x], corner[y]);
      end
      for (int n = 0; n < 8; n++) run_mult(op, $urandom, $urandom);
    end
  endtask

  task automatic probe_fw_priority;
    data_t a;
    data_t b;
    data_t ma;
    data_t mb;
    data_t csr;
    data_t expected;
    for (int k = 0; k < 8; k++) begin
      a   = $urandom;
      b   = $urandom;
      ma  = $urandom;
      mb  = $urandom;
      csr = $urandom;
      @(posedge clk);
      alu_en     <= k[0];
      mult_en    <= k[1];
      csr_access <= k[2];
      alu_req    <= '{op: ADD, a: a, b: b, c: '0};
      mult_req   <= '{op: MUL, a: ma, b: mb};
      csr_rdata  <= csr;
      if (k[2])      expected = csr;
      else if (k[1]) expected = mult_model(MUL, ma, mb);
      else if (k[0]) expected = alu_model(ADD, a, b);
      else           expected = '0;
      @(negedge clk);
      check_equal($sformatf("fw priority %0d", k), expected, fw_port.data);
    end
    @(posedge clk);
    alu_en     <= 1'b0;
    mult_en    <= 1'b0;
    csr_access <= 1'b0;
  endtask

  task automatic hold_and_flush_wb_reg;
    rf_addr_t addr;
    data_t    rdata;
    addr  = rf_addr_t'($urandom);
    rdata = $urandom;
    @(posedge clk);
    alu_en    <= 1'b1;
    wb_dest   <= '{we: 1'b1, addr: addr};
    lsu_rdata <= rdata;
    @(negedge clk);
    check_equal("ex_wb valid", 1, ex_valid);
    // Register loads here, then WB stalls
    @(posedge clk);
    alu_en   <= 1'b0;
    wb_ready <= 1'b0;
    @(negedge clk);
    check_equal("ex_wb we", 1, wb_port.we);
    check_equal("ex_wb addr", addr, wb_port.addr);
    check_equal("ex_wb data", rdata, wb_port.data);
    @(negedge clk);
    check_equal("ex_wb hold", 1, wb_port.we);
    @(posedge clk);
    wb_ready <= 1'b1;
    @(negedge clk);
    check_equal("ex_wb hold at release", 1, wb_port.we);
    // No valid with WB ready flushes
    @(negedge clk);
    check_equal("ex_wb flush", 0, wb_port.we);
  endtask

  task automatic apply_back_pressure;
    data_t a;
    data_t b;
    for (int k = 0; k < 2; k++) begin
      @(posedge clk);
      alu_en       <= 1'b1;
      lsu_ready_ex <= (k != 0);
      wb_ready     <= (k == 0);
      branch_in_ex <= 1'b0;
      @(negedge clk);
      check_equal($sformatf("stall %0d ready", k), 0, ex_ready);
      check_equal($sformatf("stall %0d valid", k), 0, ex_valid);
      @(posedge clk);
      branch_in_ex <= 1'b1;
      @(negedge clk);
      check_equal($sformatf("branch %0d ready", k), 1, ex_ready);
      check_equal($sformatf("branch %0d valid", k), 0, ex_valid);
      @(posedge clk);
      alu_en       <= 1'b0;
      branch_in_ex <= 1'b0;
      lsu_ready_ex <= 1'b1;
      wb_ready     <= 1'b1;
    end
    // High multiply finishing into a stalled WB
    a = $urandom;
    b = $urandom;
    @(posedge clk);
    mult_en  <= 1'b1;
    mult_req <= '{op: MULHU, a: a, b: b};
    wb_ready <= 1'b0;
    repeat (5) @(negedge clk);
    for (int h = 0; h < 4; h++) begin
      @(negedge clk);
      check_equal("held result", mult_model(MULHU, a, b), fw_port.data);
      check_equal("held multicycle", 1, mult_multicycle);
      check_equal("held ready", 0, ex_ready);
    end
    @(posedge clk);
    wb_ready <= 1'b1;
    @(negedge clk);
    check_equal("released ready", 1, ex_ready);
    check_equal("released result", mult_model(MULHU, a, b), fw_port.data);
    @(posedge clk);
    mult_en <= 1'b0;
    @(negedge clk);
    check_equal("back to idle", 0, mult_multicycle);
  endtask

  //////////////////////////////
  // Run control
  //////////////////////////////

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  initial begin
    void'($urandom(55));
    alu_en       = 1'b0;
    alu_req      = '0;
    mult_en      = 1'b0;
    mult_req     = '0;
    csr_access   = 1'b0;
    csr_rdata    = '0;
    lsu_en       = 1'b0;
    lsu_rdata    = '0;
    alu_dest     = '0;
    wb_dest      = '0;
    branch_in_ex = 1'b0;
    lsu_ready_ex = 1'b1;
    wb_ready     = 1'b1;
    @(posedge rst_n);
    @(negedge clk);
    check_equal("reset wb we", 0, wb_port.we);
    check_equal("reset multicycle", 0, mult_multicycle);
    sweep_alu_ops();
    verify_branch_outputs();
    exercise_multiplier();
    probe_fw_priority();
    hold_and_flush_wb_reg();
    apply_back_pressure();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 40 ns period
  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

  always #HALF_PERIOD clk_o = ~clk_o;

endmodule

`default_nettype wire
